/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= tb_line_buffer_top
RTL_TOP   ?= line_buffer_top
FILELIST  ?= line_buffer_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		-Mdir $(OBJ_DIR) -o V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_line_buffer_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lb_defines.svh"

module tb_line_buffer_top
  import lb_mem_pkg::*;
();

  localparam int LINES          = 8;
  localparam int PARTIAL_PX     = 5;
  localparam int TOTAL_PX       = LINES * `LB_DEPTH + PARTIAL_PX;
  localparam int QUIET_CYCLES   = `LB_DEPTH * 16;
  localparam int TIMEOUT_CYCLES = (LINES + 1) * `LB_DEPTH * 16 + QUIET_CYCLES + 200;
  localparam int NUM_TESTS      = 5;

  logic      clk;
  logic      rst_n;
  logic      i_px_valid;
  mem_word_t i_px_data;
  logic      o_px_ready;
  logic      o_valid;
  mem_word_t o_data;
  logic      o_start;
  logic      o_finish;

  // Pixels accepted by the DUT, oldest first.
  mem_word_t   model_q[$];
  logic [31:0] rng = 32'd62;
  int          acc_cnt = 0;
  int          out_cnt = 0;
  int          fin_cnt = 0;
  int          word_idx = 0;
  int          cycle_cnt = 0;
  int          check_cnt = 0;
  int          err_total = 0;
  int          test_err[NUM_TESTS] = '{default: 0};
  logic        prev_finish = 1'b0;

  line_buffer_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_px_valid (i_px_valid),
    .i_px_data  (i_px_data),
    .o_px_ready (o_px_ready),
    .o_valid    (o_valid),
    .o_data     (o_data),
    .o_start    (o_start),
    .o_finish   (o_finish)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      0:       return "reset and idle";
      1:       return "data order";
      2:       return "line framing";
      3:       return "pixel count";
      default: return "partial line";
    endcase
  endfunction

  task automatic check_eq(input int test_id, input string name,
                          input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      test_err[test_id]++;
      err_total++;
    end
  endtask

  task automatic flag_error(input int test_id, input string msg);
    $display("%s", msg);
    test_err[test_id]++;
    err_total++;
  endtask

  task automatic report_test(input int test_id);
    $display("test %0d (%s): %s, %0d errors", test_id + 1, test_name(test_id),
             (test_err[test_id] == 0) ? "ok" : "not ok", test_err[test_id]);
  endtask

  task automatic check_quiet_outputs(input logic with_ready);
    check_eq(0, "o_valid", 32'(o_valid), 32'd0);
    check_eq(0, "o_start", 32'(o_start), 32'd0);
    check_eq(0, "o_finish", 32'(o_finish), 32'd0);
    if (with_ready) begin
      check_eq(0, "o_px_ready", 32'(o_px_ready), 32'd0);
    end
  endtask

  // Valid is held until the DUT takes the pixel, then a new draw.
  task automatic drive_pixels(input int total);
    int last_acc;
    last_acc = -1;
    while (acc_cnt < total) begin
      @(posedge clk);
      #1;
      if (acc_cnt >= total) begin
        i_px_valid = 1'b0;
      end else if (!i_px_valid || (acc_cnt != last_acc)) begin
        rng        = xorshift32(rng);
        i_px_valid = (rng[1:0] != 2'b00);
        i_px_data  = rng[`LB_PIX_W+7:8];
        last_acc   = acc_cnt;
      end
    end
  endtask

  // Inputs and outputs are stable at the falling edge.
  always @(negedge clk) begin : monitor
    mem_word_t exp_px;
    if (rst_n) begin
      if (o_start) begin
        check_eq(2, "o_valid_at_o_start", 32'(o_valid), 32'd1);
      end
      if (o_valid) begin
        check_eq((fin_cnt == 0) ? 0 : 2, "line_written_before_output",
                 32'(acc_cnt >= (fin_cnt + 1) * `LB_DEPTH), 32'd1);
        check_eq(2, "o_start", 32'(o_start), 32'(word_idx == 0));
        check_eq(2, "o_valid_within_line", 32'(word_idx < `LB_DEPTH), 32'd1);
        if (model_q.size() == 0) begin
          flag_error(1, "o_valid seen with no accepted pixel left to compare");
        end else begin
          exp_px = model_q.pop_front();
          check_eq(1, "o_data", 32'(o_data), 32'(exp_px));
        end
        word_idx++;
        out_cnt++;
      end
      if (o_finish) begin
        check_eq(2, "words_before_o_finish", word_idx, `LB_DEPTH);
        check_eq(2, "o_finish_previous_cycle", 32'(prev_finish), 32'd0);
        word_idx = 0;
        fin_cnt++;
      end
      prev_finish = o_finish;
      if (i_px_valid && o_px_ready) begin
        model_q.push_back(i_px_data);
        acc_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int i;
    rst_n      = 1'b0;
    i_px_valid = 1'b0;
    i_px_data  = '0;

    for (i = 0; i < 3; i++) begin
      @(posedge clk);
      #1;
      if (i == 2) begin
        rst_n = 1'b1;
      end
      @(negedge clk);
      check_quiet_outputs(1'b1);
    end
    // Nothing may come out before any input.
    repeat (4) begin
      @(negedge clk);
      check_quiet_outputs(1'b0);
    end

    fork
      drive_pixels(TOTAL_PX);
      begin
        wait (fin_cnt >= 1);
        report_test(0);
      end
    join

    wait (fin_cnt >= LINES);
    report_test(1);
    report_test(2);

    // The partial line must stay inside the DUT.
    repeat (QUIET_CYCLES) @(posedge clk);
    check_eq(3, "o_valid_count", out_cnt, LINES * `LB_DEPTH);
    check_eq(3, "model_queue_left", model_q.size(), PARTIAL_PX);
    report_test(3);
    check_eq(4, "o_finish_count", fin_cnt, LINES);
    check_eq(4, "partial_line_words_out", word_idx, 0);
    report_test(4);

    $display("Summary: %0d checks, %0d errors, %0d pixels in, %0d words out, %0d lines out",
             check_cnt, err_total, acc_cnt, out_cnt, fin_cnt);
    if (err_total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* line_buffer_top.f */
+incdir+rtl
rtl/lb_mem_pkg.sv
rtl/lb_ctrl_pkg.sv
rtl/lb_mem_if.sv
rtl/line_buffer_controller.sv
rtl/lb_writer.sv
rtl/lb_reader.sv
rtl/lb_mem_arbiter.sv
rtl/lb_line_mem.sv
rtl/line_buffer_top.sv
dv/tb_line_buffer_top.sv

/* rtl/lb_ctrl_pkg.sv */
`default_nettype none

package lb_ctrl_pkg;

  typedef enum logic [2:0] {
    IDLE       = 3'b000,
    START      = 3'b001,
    FIRST_READ = 3'b010,
    READ1      = 3'b011,
    READ2      = 3'b100,
    DONE       = 3'b101
  } lb_state_e;

endpackage

`default_nettype wire

/* rtl/lb_defines.svh */
`ifndef LB_DEFINES_SVH
`define LB_DEFINES_SVH

// Pixels per line.
`define LB_DEPTH 16

`define LB_PIX_W 8

// One extra bit selects the bank.
`define LB_ADDR_W 5

`define LB_MEM_WORDS (2 * `LB_DEPTH)

`endif

/* rtl/lb_line_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lb_defines.svh"

module lb_line_mem
  import lb_mem_pkg::*;
(
  input  logic      clk,
  input  logic      i_en,
  input  logic      i_we,
  input  mem_addr_t i_addr,
  input  mem_word_t i_wdata,
  output mem_word_t o_rdata
);

  mem_word_t mem_q [`LB_MEM_WORDS];

  // Read data holds until the next access.
  always_ff @(posedge clk) begin
    if (i_en) begin
      if (i_we) begin
        mem_q[i_addr] <= i_wdata;
      end else begin
        o_rdata <= mem_q[i_addr];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/lb_mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module lb_mem_arbiter
  import lb_mem_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  lb_mem_if.arbiter wr_port,
  lb_mem_if.arbiter rd_port,
  output logic      o_mem_en,
  output logic      o_mem_we,
  output mem_addr_t o_mem_addr,
  output mem_word_t o_mem_wdata,
  input  mem_word_t i_mem_rdata
);

  logic wr_ack;
  logic rd_ack;
  logic last_rd;
  logic busy;
  logic pick_rd;
  logic grant;

  // Grant is held while either ack is up.
  assign busy    = wr_ack || rd_ack;
  assign pick_rd = rd_port.req && (!wr_port.req || !last_rd);
  assign grant   = !busy && (wr_port.req || rd_port.req);

  always_comb begin
    o_mem_en    = grant;
    o_mem_we    = pick_rd ? rd_port.we : wr_port.we;
    o_mem_addr  = pick_rd ? rd_port.addr : wr_port.addr;
    o_mem_wdata = pick_rd ? rd_port.wdata : wr_port.wdata;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ack  <= 1'b0;
      rd_ack  <= 1'b0;
      last_rd <= 1'b0;
    end else if (grant) begin
      rd_ack  <= pick_rd;
      wr_ack  <= !pick_rd;
      last_rd <= pick_rd;
    end else begin
      if (wr_ack && !wr_port.req) begin
        wr_ack <= 1'b0;
      end
      if (rd_ack && !rd_port.req) begin
        rd_ack <= 1'b0;
      end
    end
  end

  assign wr_port.ack   = wr_ack;
  assign rd_port.ack   = rd_ack;
  assign wr_port.rdata = i_mem_rdata;
  assign rd_port.rdata = i_mem_rdata;

  a_ack_onehot: assert property (
    @(posedge clk) disable iff (!rst_n) !(wr_port.ack && rd_port.ack)
  );

endmodule

`default_nettype wire

/* rtl/lb_mem_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface lb_mem_if
  import lb_mem_pkg::*;
();

  logic      req;
  logic      we;
  mem_addr_t addr;
  mem_word_t wdata;
  logic      ack;
  // Valid while ack is high.
  mem_word_t rdata;

  modport requester (
    output req, we, addr, wdata,
    input  ack, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output ack, rdata
  );

endinterface

`default_nettype wire

/* rtl/lb_mem_pkg.sv */
`default_nettype none

`include "lb_defines.svh"

package lb_mem_pkg;

  // Top bit is the bank.
  typedef logic [`LB_ADDR_W-1:0] mem_addr_t;

  typedef logic [`LB_PIX_W-1:0] mem_word_t;

endpackage

`default_nettype wire

/* rtl/lb_reader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lb_defines.svh"

module lb_reader
  import lb_mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_rd_en,
  input  logic       i_reset_en,
  input  logic       i_line_bank,
  output logic       o_first_done,
  output logic       o_last_done,
  output logic       o_valid,
  output mem_word_t  o_data,
  lb_mem_if.requester mem
);

  localparam logic [`LB_ADDR_W-2:0] LAST_IDX = (`LB_ADDR_W-1)'(`LB_DEPTH - 1);

  logic [`LB_ADDR_W-2:0] cnt;
  logic rd_bank;
  logic active;
  logic held;
  logic req;
  logic take;
  logic issue;

  assign take  = req && mem.ack;
  // Word 0 is prefetched before the controller enables reads.
  assign issue = active && !req && !mem.ack && ((cnt == '0) || i_rd_en);

  assign o_first_done = take && (cnt == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt         <= '0;
      rd_bank     <= 1'b1;
      active      <= 1'b0;
      held        <= 1'b0;
      req         <= 1'b0;
      o_valid     <= 1'b0;
      o_last_done <= 1'b0;
    end else begin
      o_valid     <= 1'b0;
      o_last_done <= 1'b0;
      // The writer's bank flips only when a line is handed over.
      if (!active && (i_line_bank != rd_bank)) begin
        rd_bank <= i_line_bank;
        active  <= 1'b1;
      end
      if (issue) begin
        req <= 1'b1;
      end else if (take) begin
        req <= 1'b0;
        cnt <= cnt + 1'b1;
        if (cnt == '0) begin
          held <= 1'b1;
        end else begin
          o_valid     <= 1'b1;
          o_last_done <= (cnt == LAST_IDX);
        end
        if (cnt == LAST_IDX) begin
          active <= 1'b0;
        end
      end
      // First word shows up together with o_start.
      if (held && i_rd_en) begin
        o_valid <= 1'b1;
        held    <= 1'b0;
      end
      if (i_reset_en) begin
        cnt  <= '0;
        held <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      o_data <= mem.rdata;
    end
  end

  assign mem.req   = req;
  assign mem.we    = 1'b0;
  assign mem.addr  = {rd_bank, cnt};
  assign mem.wdata = '0;

endmodule

`default_nettype wire

/* rtl/lb_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lb_defines.svh"

module lb_writer
  import lb_mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_px_valid,
  input  mem_word_t  i_px_data,
  output logic       o_px_ready,
  input  logic       i_line_accept,
  output logic       o_line_done,
  output logic       o_line_bank,
  lb_mem_if.requester mem
);

  localparam logic [`LB_ADDR_W-2:0] LAST_IDX = (`LB_ADDR_W-1)'(`LB_DEPTH - 1);

  logic [`LB_ADDR_W-2:0] cnt;
  logic      wr_bank;
  logic      full;
  logic      req;
  logic      armed;
  logic      line_push;
  logic      px_take;
  mem_addr_t addr_q;
  mem_word_t wdata_q;

  assign line_push  = full && !req && !mem.ack && i_line_accept;
  assign o_px_ready = armed && !req && !mem.ack && (!full || i_line_accept);
  assign px_take    = i_px_valid && o_px_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt         <= '0;
      wr_bank     <= 1'b0;
      full        <= 1'b0;
      req         <= 1'b0;
      armed       <= 1'b0;
      o_line_done <= 1'b0;
      o_line_bank <= 1'b1;
    end else begin
      armed       <= 1'b1;
      o_line_done <= 1'b0;
      if (line_push) begin
        o_line_done <= 1'b1;
        o_line_bank <= wr_bank;
        wr_bank     <= ~wr_bank;
        full        <= 1'b0;
      end
      if (px_take) begin
        req <= 1'b1;
        cnt <= cnt + 1'b1;
        if (cnt == LAST_IDX) begin
          full <= 1'b1;
        end
      end else if (req && mem.ack) begin
        req <= 1'b0;
      end
    end
  end

  // A pixel taken alongside the hand-over goes to the next bank.
  always_ff @(posedge clk) begin
    if (px_take) begin
      addr_q  <= {wr_bank ^ full, cnt};
      wdata_q <= i_px_data;
    end
  end

  assign mem.req   = req;
  assign mem.we    = 1'b1;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  a_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
      (mem.req && !mem.ack) |=> ($stable(mem.addr) && $stable(mem.wdata))
  );

endmodule

`default_nettype wire

/* rtl/line_buffer_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer_controller
  import lb_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_line_done,
  input  logic      i_first_done,
  input  logic      i_last_done,
  output logic      o_rd_en,
  output logic      o_reset_en,
  output logic      o_line_accept,
  output logic      o_start,
  output logic      o_finish,
  output lb_state_e o_state
);

  lb_state_e state;
  lb_state_e state_nxt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:       state_nxt = i_line_done ? START : IDLE;
      START:      state_nxt = i_first_done ? FIRST_READ : START;
      FIRST_READ: state_nxt = READ1;
      READ1:      state_nxt = READ2;
      READ2:      state_nxt = i_last_done ? DONE : READ2;
      DONE:       state_nxt = IDLE;
      default:    state_nxt = IDLE;
    endcase
  end

  // Writer may hand over a new line only between replays.
  assign o_line_accept = (state == IDLE);
  assign o_rd_en       = (state == FIRST_READ) || (state == READ1) || (state == READ2);
  assign o_start       = (state == READ1);
  assign o_finish      = (state == DONE);
  assign o_reset_en    = (state == DONE);
  assign o_state       = state;

  a_start_finish_excl: assert property (
    @(posedge clk) disable iff (!rst_n) !(o_start && o_finish)
  );

  a_state_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
      state inside {IDLE, START, FIRST_READ, READ1, READ2, DONE}
  );

endmodule

`default_nettype wire

/* rtl/line_buffer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer_top
  import lb_mem_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_px_valid,
  input  mem_word_t i_px_data,
  output logic      o_px_ready,
  output logic      o_valid,
  output mem_word_t o_data,
  output logic      o_start,
  output logic      o_finish
);

  logic      line_done;
  logic      line_bank;
  logic      line_accept;
  logic      rd_en;
  logic      reset_en;
  logic      first_done;
  logic      last_done;
  logic      mem_en;
  logic      mem_we;
  mem_addr_t mem_addr;
  mem_word_t mem_wdata;
  mem_word_t mem_rdata;

  lb_mem_if wr_if ();
  lb_mem_if rd_if ();

  lb_writer u_writer (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_px_valid    (i_px_valid),
    .i_px_data     (i_px_data),
    .o_px_ready    (o_px_ready),
    .i_line_accept (line_accept),
    .o_line_done   (line_done),
    .o_line_bank   (line_bank),
    .mem           (wr_if.requester)
  );

  lb_reader u_reader (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_rd_en      (rd_en),
    .i_reset_en   (reset_en),
    .i_line_bank  (line_bank),
    .o_first_done (first_done),
    .o_last_done  (last_done),
    .o_valid      (o_valid),
    .o_data       (o_data),
    .mem          (rd_if.requester)
  );

  line_buffer_controller u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_line_done   (line_done),
    .i_first_done  (first_done),
    .i_last_done   (last_done),
    .o_rd_en       (rd_en),
    .o_reset_en    (reset_en),
    .o_line_accept (line_accept),
    .o_start       (o_start),
    .o_finish      (o_finish),
    .o_state       ()
  );

  lb_mem_arbiter u_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_port     (wr_if.arbiter),
    .rd_port     (rd_if.arbiter),
    .o_mem_en    (mem_en),
    .o_mem_we    (mem_we),
    .o_mem_addr  (mem_addr),
    .o_mem_wdata (mem_wdata),
    .i_mem_rdata (mem_rdata)
  );

  lb_line_mem u_mem (
    .clk     (clk),
    .i_en    (mem_en),
    .i_we    (mem_we),
    .i_addr  (mem_addr),
    .i_wdata (mem_wdata),
    .o_rdata (mem_rdata)
  );

endmodule

`default_nettype wire
